// File: sprite_gfx_settings.svh
`ifndef SPRITE_GFX_SETTINGS_SVH
`define SPRITE_GFX_SETTINGS_SVH

// Visible display area in pixels
`define SCREEN_WIDTH 640
`define SCREEN_HEIGHT 400

// One frame buffer entry per visible pixel
`define FB_DEPTH 256000

// Clocks between two engine steps
// Each pixel takes this many clocks
`define PIXEL_TICK_DIV 2

`endif

// File: sprite_gfx_pkg.sv
package sprite_gfx_pkg;

    // Cursor coordinate or draw width
    typedef logic [9:0] coord_t;

    // Linear frame buffer address, x plus y times screen width
    typedef logic [17:0] fb_addr_t;

    // Palette index stored per pixel
    typedef logic [3:0] pixel_t;

    typedef logic [7:0] data_byte_t;
    typedef logic [3:0] palette_offset_t;

    // Pixels still to draw from the current byte
    typedef logic [3:0] pixel_count_t;

    // Bit packing of a sprite data byte
    typedef enum logic [1:0] {
        MODE_1BPP             = 2'b00,
        MODE_1BPP_TRANSPARENT = 2'b01,
        MODE_2BPP             = 2'b10,
        MODE_4BPP             = 2'b11
    } color_mode_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_WAIT_BYTE,
        ENG_DRAW,
        ENG_REPORT
    } engine_state_t;

endpackage

// File: pixel_color_mapper.sv
`timescale 1ns/10ps

module pixel_color_mapper (
    input  sprite_gfx_pkg::data_byte_t      byte_value,
    input  sprite_gfx_pkg::pixel_count_t    pixel_index,
    input  sprite_gfx_pkg::color_mode_t     color_mode,
    input  sprite_gfx_pkg::palette_offset_t palette_offset,
    output sprite_gfx_pkg::pixel_t          pixel_value,
    output logic                            transparent
);

    // Byte shifted so the current pixel sits in the top bits
    sprite_gfx_pkg::data_byte_t aligned;

    // Raw field value before the palette offset
    sprite_gfx_pkg::pixel_t field;

    always_comb begin
        aligned     = '0;
        field       = '0;
        transparent = 1'b0;

        case (color_mode)
            sprite_gfx_pkg::MODE_1BPP: begin
                aligned = byte_value << pixel_index;
                field   = {3'b000, aligned[7]};
            end

            sprite_gfx_pkg::MODE_1BPP_TRANSPARENT: begin
                aligned     = byte_value << pixel_index;
                field       = {3'b000, aligned[7]};
                // Zero bits leave the frame buffer untouched
                transparent = ~aligned[7];
            end

            // Two pixels per nibble, index steps by two bits
            sprite_gfx_pkg::MODE_2BPP: begin
                aligned = byte_value << {pixel_index, 1'b0};
                field   = {2'b00, aligned[7:6]};
            end

            sprite_gfx_pkg::MODE_4BPP: begin
                aligned = byte_value << {pixel_index, 2'b00};
                field   = aligned[7:4];
            end

            default: begin
                field = '0;
            end
        endcase
    end

    // Palette offset wraps modulo 16 through the 4-bit sum
    assign pixel_value = field + palette_offset;

endmodule

// File: sprite_engine.sv
`timescale 1ns/10ps
`include "sprite_gfx_settings.svh"

module sprite_engine (
    input  logic                            clock_in,
    input  logic                            arst_n,

    input  sprite_gfx_pkg::coord_t          cursor_start_x,
    input  sprite_gfx_pkg::coord_t          cursor_start_y,
    input  sprite_gfx_pkg::coord_t          draw_width,
    input  sprite_gfx_pkg::color_mode_t     color_mode,
    input  sprite_gfx_pkg::palette_offset_t palette_offset,

    input  logic                            draw_enable,
    input  logic                            draw_data_valid,
    input  sprite_gfx_pkg::data_byte_t      draw_data,

    input  sprite_gfx_pkg::pixel_t          pixel_value,
    input  logic                            transparent,

    output sprite_gfx_pkg::data_byte_t      byte_value,
    output sprite_gfx_pkg::pixel_count_t    pixel_index,
    output sprite_gfx_pkg::color_mode_t     byte_mode,
    output sprite_gfx_pkg::palette_offset_t byte_offset,

    output logic                            write_enable,
    output sprite_gfx_pkg::fb_addr_t        write_address,
    output sprite_gfx_pkg::pixel_t          write_data,

    output logic                            cursor_end_valid,
    output sprite_gfx_pkg::coord_t          cursor_end_x,
    output sprite_gfx_pkg::coord_t          cursor_end_y
);

    localparam int unsigned TICK_W = $clog2(`PIXEL_TICK_DIV + 1);
    localparam int unsigned ADDR_W = $bits(sprite_gfx_pkg::fb_addr_t);

    sprite_gfx_pkg::engine_state_t state;

    logic [TICK_W-1:0] tick_count;
    logic              tick;

    logic enable_q;
    logic data_valid_q;
    logic enable_rise;
    logic valid_rise;
    logic start_pending;
    logic byte_pending;

    logic start_now;
    logic accept_byte;
    logic draw_step;
    logic report_step;

    sprite_gfx_pkg::pixel_count_t pixels_left;

    sprite_gfx_pkg::coord_t cursor_x;
    sprite_gfx_pkg::coord_t cursor_y;
    sprite_gfx_pkg::coord_t left_boundary;
    sprite_gfx_pkg::coord_t right_boundary;
    logic                   last_in_row;

    // Two spare bits catch addresses past the 18-bit range
    logic [ADDR_W+1:0] address_wide;

    function automatic sprite_gfx_pkg::pixel_count_t pixels_per_byte(
        input sprite_gfx_pkg::color_mode_t mode
    );
        case (mode)
            sprite_gfx_pkg::MODE_2BPP: return 4'd4;
            sprite_gfx_pkg::MODE_4BPP: return 4'd2;
            default:                   return 4'd8;
        endcase
    endfunction

    assign tick = draw_enable && (tick_count == TICK_W'(`PIXEL_TICK_DIV - 1));

    assign enable_rise = draw_enable & ~enable_q;
    assign valid_rise  = draw_data_valid & ~data_valid_q;

    assign start_now   = tick && (state == sprite_gfx_pkg::ENG_IDLE)
                         && (start_pending || enable_rise);
    assign accept_byte = tick && (state == sprite_gfx_pkg::ENG_WAIT_BYTE)
                         && (byte_pending || valid_rise);
    assign draw_step   = tick && (state == sprite_gfx_pkg::ENG_DRAW);
    assign report_step = tick && (state == sprite_gfx_pkg::ENG_REPORT);

    assign pixel_index = pixels_per_byte(byte_mode) - pixels_left;

    // Row ends once draw_width pixels have been placed
    assign last_in_row = (sprite_gfx_pkg::coord_t'(cursor_x + 1'b1) >= right_boundary);

    assign address_wide = (ADDR_W+2)'(cursor_x)
                          + (ADDR_W+2)'(cursor_y) * (ADDR_W+2)'(`SCREEN_WIDTH);

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            state            <= sprite_gfx_pkg::ENG_IDLE;
            tick_count       <= '0;
            enable_q         <= 1'b0;
            data_valid_q     <= 1'b0;
            start_pending    <= 1'b0;
            byte_pending     <= 1'b0;
            pixels_left      <= '0;
            write_enable     <= 1'b0;
            cursor_end_valid <= 1'b0;
        end else if (!draw_enable) begin
            // Abort, the next rise starts a fresh sequence
            state            <= sprite_gfx_pkg::ENG_IDLE;
            tick_count       <= '0;
            enable_q         <= 1'b0;
            data_valid_q     <= 1'b0;
            start_pending    <= 1'b0;
            byte_pending     <= 1'b0;
            pixels_left      <= '0;
            write_enable     <= 1'b0;
            cursor_end_valid <= 1'b0;
        end else begin
            write_enable     <= 1'b0;
            cursor_end_valid <= 1'b0;
            enable_q         <= 1'b1;
            data_valid_q     <= draw_data_valid;
            tick_count       <= tick ? '0 : tick_count + 1'b1;

            // Hold edges seen between ticks
            if (enable_rise) begin
                start_pending <= 1'b1;
            end
            if (valid_rise) begin
                byte_pending <= 1'b1;
            end

            if (start_now) begin
                start_pending <= 1'b0;
                state         <= sprite_gfx_pkg::ENG_WAIT_BYTE;
            end

            if (accept_byte) begin
                byte_pending <= 1'b0;
                pixels_left  <= pixels_per_byte(color_mode);
                state        <= sprite_gfx_pkg::ENG_DRAW;
            end

            if (draw_step) begin
                write_enable <= ~transparent;
                pixels_left  <= pixels_left - 1'b1;
                if (pixels_left == 4'd1) begin
                    state <= sprite_gfx_pkg::ENG_REPORT;
                end
            end

            if (report_step) begin
                cursor_end_valid <= 1'b1;
                state            <= sprite_gfx_pkg::ENG_WAIT_BYTE;
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (start_now) begin
            cursor_x       <= cursor_start_x;
            cursor_y       <= cursor_start_y;
            left_boundary  <= cursor_start_x;
            right_boundary <= cursor_start_x + draw_width;
        end

        if (accept_byte) begin
            byte_value  <= draw_data;
            byte_mode   <= color_mode;
            byte_offset <= palette_offset;
        end

        if (draw_step) begin
            // Out of range addresses saturate so the frame buffer drops them
            if (address_wide[ADDR_W+1 -: 2] != 2'b00) begin
                write_address <= '1;
            end else begin
                write_address <= address_wide[ADDR_W-1:0];
            end
            write_data <= pixel_value;

            if (last_in_row) begin
                cursor_x <= left_boundary;
                cursor_y <= cursor_y + 1'b1;
            end else begin
                cursor_x <= cursor_x + 1'b1;
            end
        end

        // Cursor already points at the next pixel
        if (report_step) begin
            cursor_end_x <= cursor_x;
            cursor_end_y <= cursor_y;
        end
    end

    // A write always comes from a step taken in the draw state
    assert property (@(posedge clock_in) disable iff (!arst_n)
        write_enable |-> $past(state) == sprite_gfx_pkg::ENG_DRAW);

    assert property (@(posedge clock_in) disable iff (!arst_n)
        cursor_end_valid |=> !cursor_end_valid);

    assert property (@(posedge clock_in) disable iff (!arst_n)
        (state != sprite_gfx_pkg::ENG_IDLE) |-> (cursor_x <= right_boundary));

    // Index handed to the mapper stays inside the byte
    assert property (@(posedge clock_in) disable iff (!arst_n)
        (state == sprite_gfx_pkg::ENG_DRAW) |-> (pixel_index < pixels_per_byte(byte_mode)));

endmodule

// File: frame_buffer.sv
`timescale 1ns/10ps
`include "sprite_gfx_settings.svh"

module frame_buffer (
    input  logic                     clock_in,

    input  logic                     write_enable,
    input  sprite_gfx_pkg::fb_addr_t write_address,
    input  sprite_gfx_pkg::pixel_t   write_data,

    input  sprite_gfx_pkg::fb_addr_t read_address,
    output sprite_gfx_pkg::pixel_t   read_data
);

    // Blank screen at start of simulation
    sprite_gfx_pkg::pixel_t memory [`FB_DEPTH] = '{default: '0};

    // Writes past the last entry are dropped
    always_ff @(posedge clock_in) begin
        if (write_enable && (write_address < `FB_DEPTH)) begin
            memory[write_address] <= write_data;
        end
    end

    always_ff @(posedge clock_in) begin
        if (read_address < `FB_DEPTH) begin
            read_data <= memory[read_address];
        end else begin
            read_data <= '0;
        end
    end

endmodule

// File: sprite_gfx_top.sv
`timescale 1ns/10ps

module sprite_gfx_top (
    input  logic                            clock_in,
    input  logic                            arst_n,

    input  sprite_gfx_pkg::coord_t          cursor_start_x,
    input  sprite_gfx_pkg::coord_t          cursor_start_y,
    input  sprite_gfx_pkg::coord_t          draw_width,
    input  sprite_gfx_pkg::color_mode_t     color_mode,
    input  sprite_gfx_pkg::palette_offset_t palette_offset,

    input  logic                            draw_enable,
    input  logic                            draw_data_valid,
    input  sprite_gfx_pkg::data_byte_t      draw_data,

    output logic                            cursor_end_valid,
    output sprite_gfx_pkg::coord_t          cursor_end_x,
    output sprite_gfx_pkg::coord_t          cursor_end_y,

    input  sprite_gfx_pkg::fb_addr_t        read_address,
    output sprite_gfx_pkg::pixel_t          read_data
);

    // Engine to mapper
    sprite_gfx_pkg::data_byte_t      byte_value;
    sprite_gfx_pkg::pixel_count_t    pixel_index;
    sprite_gfx_pkg::color_mode_t     byte_mode;
    sprite_gfx_pkg::palette_offset_t byte_offset;
    sprite_gfx_pkg::pixel_t          pixel_value;
    logic                            transparent;

    // Engine to frame buffer
    logic                            write_enable;
    sprite_gfx_pkg::fb_addr_t        write_address;
    sprite_gfx_pkg::pixel_t          write_data;

    sprite_engine u_engine (
        .clock_in         (clock_in),
        .arst_n           (arst_n),
        .cursor_start_x   (cursor_start_x),
        .cursor_start_y   (cursor_start_y),
        .draw_width       (draw_width),
        .color_mode       (color_mode),
        .palette_offset   (palette_offset),
        .draw_enable      (draw_enable),
        .draw_data_valid  (draw_data_valid),
        .draw_data        (draw_data),
        .pixel_value      (pixel_value),
        .transparent      (transparent),
        .byte_value       (byte_value),
        .pixel_index      (pixel_index),
        .byte_mode        (byte_mode),
        .byte_offset      (byte_offset),
        .write_enable     (write_enable),
        .write_address    (write_address),
        .write_data       (write_data),
        .cursor_end_valid (cursor_end_valid),
        .cursor_end_x     (cursor_end_x),
        .cursor_end_y     (cursor_end_y)
    );

    pixel_color_mapper u_mapper (
        .byte_value     (byte_value),
        .pixel_index    (pixel_index),
        .color_mode     (byte_mode),
        .palette_offset (byte_offset),
        .pixel_value    (pixel_value),
        .transparent    (transparent)
    );

    frame_buffer u_frame_buffer (
        .clock_in      (clock_in),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data),
        .read_address  (read_address),
        .read_data     (read_data)
    );

endmodule

// File: tb_sprite_gfx.sv
`timescale 1ns/10ps

module tb_sprite_gfx;

    logic                            clock_in;
    logic                            arst_n;
    sprite_gfx_pkg::coord_t          cursor_start_x;
    sprite_gfx_pkg::coord_t          cursor_start_y;
    sprite_gfx_pkg::coord_t          draw_width;
    sprite_gfx_pkg::color_mode_t     color_mode;
    sprite_gfx_pkg::palette_offset_t palette_offset;
    logic                            draw_enable;
    logic                            draw_data_valid;
    sprite_gfx_pkg::data_byte_t      draw_data;
    logic                            cursor_end_valid;
    sprite_gfx_pkg::coord_t          cursor_end_x;
    sprite_gfx_pkg::coord_t          cursor_end_y;
    sprite_gfx_pkg::fb_addr_t        read_address;
    sprite_gfx_pkg::pixel_t          read_data;

    logic [15:0] lfsr_state;
    string       lines[$];
    int          error_count;
    int          test_errors;
    int          test_count;

    sprite_gfx_top u_dut (
        .clock_in         (clock_in),
        .arst_n           (arst_n),
        .cursor_start_x   (cursor_start_x),
        .cursor_start_y   (cursor_start_y),
        .draw_width       (draw_width),
        .color_mode       (color_mode),
        .palette_offset   (palette_offset),
        .draw_enable      (draw_enable),
        .draw_data_valid  (draw_data_valid),
        .draw_data        (draw_data),
        .cursor_end_valid (cursor_end_valid),
        .cursor_end_x     (cursor_end_x),
        .cursor_end_y     (cursor_end_y),
        .read_address     (read_address),
        .read_data        (read_data)
    );

    initial begin
        clock_in = 1'b0;
        forever #5 clock_in = ~clock_in;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic next_lfsr_bit();
        logic feedback;
        feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], feedback};
        return feedback;
    endfunction

    // Data-valid low time of 1 to 4 clocks
    function automatic int random_gap();
        int gap;
        gap = 0;
        repeat (2) begin
            gap = (gap << 1) | int'(next_lfsr_bit());
        end
        return gap + 1;
    endfunction

    task automatic check_coord(input string name, input sprite_gfx_pkg::coord_t expected,
                               input sprite_gfx_pkg::coord_t actual);
        if (actual !== expected) begin
            $display("error %s expected %h got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_pixel(input string name, input sprite_gfx_pkg::pixel_t expected,
                               input sprite_gfx_pkg::pixel_t actual);
        if (actual !== expected) begin
            $display("error %s expected %h got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    // Comment lines start with a hash
    task automatic load_patterns();
        int    fd;
        string text;
        fd = $fopen("sprite_gfx_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open sprite_gfx_patterns.txt");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            if ($fgets(text, fd) != 0) begin
                if (text.len() > 1 && text[0] != "#") begin
                    lines.push_back(text);
                end
            end
        end
        $fclose(fd);
    endtask

    // Read port has one clock of latency
    task automatic read_pixel(input int address, input int value);
        @(negedge clock_in);
        read_address = sprite_gfx_pkg::fb_addr_t'(address);
        @(negedge clock_in);
        check_pixel($sformatf("read_data[%0d]", address), sprite_gfx_pkg::pixel_t'(value),
                    read_data);
    endtask

    task automatic wait_report(input int byte_number, input int end_x, input int end_y);
        int waited;
        waited = 0;
        @(negedge clock_in);
        while (!cursor_end_valid && waited < 40) begin
            @(negedge clock_in);
            waited++;
        end
        if (!cursor_end_valid) begin
            $display("no cursor_end_valid within 40 clocks of byte %0d", byte_number);
            test_errors++;
        end else begin
            check_coord("cursor_end_x", sprite_gfx_pkg::coord_t'(end_x), cursor_end_x);
            check_coord("cursor_end_y", sprite_gfx_pkg::coord_t'(end_y), cursor_end_y);
        end
        draw_data_valid = 1'b0;
    endtask

    // Drop enable mid byte, then no report may follow
    task automatic abort_byte(input int stop);
        repeat (stop) @(negedge clock_in);
        draw_enable     = 1'b0;
        draw_data_valid = 1'b0;
        repeat (40) begin
            @(negedge clock_in);
            if (cursor_end_valid) begin
                $display("cursor report seen after the sequence was aborted");
                test_errors++;
            end
        end
    endtask

    task automatic run_test(inout int index);
        string name;
        int    start_x, start_y, width, mode, offset;
        int    byte_count, pixel_count, fields;
        int    data, end_x, end_y, stop, address, value;
        logic  aborted;
        test_errors = 0;
        aborted     = 1'b0;
        fields = $sscanf(lines[index], "%s %d %d %d %d %h %d %d", name, start_x, start_y,
                         width, mode, offset, byte_count, pixel_count);
        index++;
        if (fields != 8) begin
            $display("pattern line %0d is not a test line", index);
            error_count++;
            index = lines.size();
            return;
        end
        @(negedge clock_in);
        cursor_start_x  = sprite_gfx_pkg::coord_t'(start_x);
        cursor_start_y  = sprite_gfx_pkg::coord_t'(start_y);
        draw_width      = sprite_gfx_pkg::coord_t'(width);
        color_mode      = sprite_gfx_pkg::color_mode_t'(mode);
        palette_offset  = sprite_gfx_pkg::palette_offset_t'(offset);
        draw_enable     = 1'b1;
        draw_data_valid = 1'b0;
        for (int b = 0; b < byte_count; b++) begin
            void'($sscanf(lines[index], "%h %d %d %d", data, end_x, end_y, stop));
            index++;
            if (!aborted) begin
                @(negedge clock_in);
                draw_data       = sprite_gfx_pkg::data_byte_t'(data);
                draw_data_valid = 1'b1;
                if (stop > 0) begin
                    abort_byte(stop);
                    aborted = 1'b1;
                end else begin
                    wait_report(b, end_x, end_y);
                    repeat (random_gap() - 1) @(negedge clock_in);
                end
            end
        end
        @(negedge clock_in);
        draw_enable = 1'b0;
        for (int p = 0; p < pixel_count; p++) begin
            void'($sscanf(lines[index], "%d %h", address, value));
            index++;
            read_pixel(address, value);
        end
        $display("%s %s", name, (test_errors == 0) ? "passed" : "failed");
        error_count += test_errors;
        test_count++;
    endtask

    initial begin
        int index;
        int limit_ns;
        arst_n          = 1'b0;
        cursor_start_x  = '0;
        cursor_start_y  = '0;
        draw_width      = '0;
        color_mode      = sprite_gfx_pkg::MODE_1BPP;
        palette_offset  = '0;
        draw_enable     = 1'b0;
        draw_data_valid = 1'b0;
        draw_data       = '0;
        read_address    = '0;
        // Seed keeps its low 16 bits
        lfsr_state      = 16'(72533);
        error_count     = 0;
        test_count      = 0;
        load_patterns();
        limit_ns = (lines.size() + 1) * 2000;
        fork
            begin
                #(limit_ns);
                $display("watchdog expired after %0d ns", limit_ns);
                $display("Done: errors found");
                $finish;
            end
        join_none
        repeat (2) @(posedge clock_in);
        @(negedge clock_in);
        arst_n = 1'b1;
        index  = 0;
        while (index < lines.size()) begin
            run_test(index);
        end
        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sprite_gfx_patterns.txt
# test line: name x y width mode offset(hex) bytes pixels; byte line: data(hex) end_x end_y stop
# stop above 0 drops draw_enable that many clocks after data-valid; pixel line: address value(hex)
bpp4_single 10 5 16 3 0 1 2
a7 12 5 0
3210 a
3211 7
bpp1_opaque 100 20 16 0 3 1 8
b5 108 20 0
12900 4
12901 3
12902 4
12903 4
12904 3
12905 4
12906 3
12907 4
bpp4_backdrop 200 30 8 3 0 4 0
12 202 30 0
34 204 30 0
56 206 30 0
78 200 31 0
bpp1_transparent 200 30 8 1 5 1 8
96 200 31 0
19400 6
19401 2
19402 3
19403 6
19404 5
19405 6
19406 6
19407 8
bpp2_offset 300 40 16 2 e 1 4
f4 304 40 0
25900 1
25901 1
25902 f
25903 e
width3_wrap 50 60 3 3 0 2 5
12 52 60 0
34 51 61 0
38450 1
38451 2
38452 3
38453 0
39090 4
abort_mid_byte 400 80 16 0 0 1 3
ff 0 0 7
51600 1
51601 1
51602 0
restart_after_abort 400 81 16 3 2 1 2
9c 402 81 0
52240 b
52241 e

// File: sprite_gfx.f
+incdir+.
sprite_gfx_pkg.sv
pixel_color_mapper.sv
sprite_engine.sv
frame_buffer.sv
sprite_gfx_top.sv
tb_sprite_gfx.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the sprite graphics testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_sprite_gfx \
    -f sprite_gfx.f -o sim_sprite_gfx

./obj_dir/sim_sprite_gfx | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
